/* design/i8080_pkg.sv */
// 8080-lite shared definitions: opcode views, cycle states, bus status bits and widths
package i8080_pkg;

   localparam int ADDR_W = 16;
   localparam int DATA_W = 8;

   // T-states of one machine cycle
   typedef enum logic [2:0] {T1, T2, TW, T3, T4} tstate_e;

   typedef enum logic [1:0] {FETCH, READ, WRITE, HALT} mcycle_e;

   // same order as the middle opcode field of the ALU group
   typedef enum logic [2:0] {ADD, ADC, SUB, SBB, ANA, XRA, ORA, CMP} alu_op_e;

   typedef struct packed {
      logic [1:0] group;
      logic [2:0] dst;
      logic [2:0] src;
   } mov_fields_t;

   typedef struct packed {
      logic [1:0] group;
      alu_op_e    alu_op;
      logic [2:0] src;
   } op_fields_t;

   // one opcode byte, read as a move or as an ALU operation
   typedef union packed {
      mov_fields_t mov;
      op_fields_t  op;
   } opcode_u;

   localparam logic [2:0] REG_M = 3'd6;
   localparam logic [2:0] REG_A = 3'd7;

   localparam logic [7:0] OP_HLT = 8'h76;
   localparam logic [7:0] OP_JMP = 8'hc3;
   localparam logic [7:0] OP_OUT = 8'hd3;

   // row patterns, compared on group and src bits only
   localparam logic [7:0] OP_ROW_MASK = 8'hc7;
   localparam logic [7:0] OP_MVI_MASK = 8'h06;
   localparam logic [7:0] OP_JCC_MASK = 8'hc2;

   // status byte on the data bus during T1
   localparam int STATUS_WO_N = 1;
   localparam int STATUS_HLTA = 3;
   localparam int STATUS_OUT  = 4;
   localparam int STATUS_M1   = 5;
   localparam int STATUS_MEMR = 7;

   // bit positions in the 4-bit flag vector
   localparam int FLAG_CY = 0;
   localparam int FLAG_P  = 1;
   localparam int FLAG_S  = 2;
   localparam int FLAG_Z  = 3;

endpackage

/* design/cycle_ctrl_if.sv */
`timescale 1ns/10ps
// steering from the instruction sequencer to the counter, datapath and bus blocks
interface cycle_ctrl_if;

   i8080_pkg::tstate_e tstate;
   i8080_pkg::mcycle_e mcycle;

   // datapath writes, taken on the next edge
   logic                         reg_we;
   logic                         acc_we;
   logic                         alu_exec;
   logic [2:0]                   dst;
   logic [2:0]                   src;
   i8080_pkg::alu_op_e           alu_op;
   logic                         imm_sel;

   // program counter control
   logic                         pc_inc;
   logic                         lo_we;
   logic                         pc_load;

   logic [i8080_pkg::DATA_W-1:0] port_addr;

   modport seq (
      output tstate, mcycle, reg_we, acc_we, alu_exec, dst, src, alu_op, imm_sel,
      output pc_inc, lo_we, pc_load, port_addr
   );

   modport counter (input pc_inc, lo_we, pc_load);

   modport datapath (input reg_we, acc_we, alu_exec, dst, src, alu_op, imm_sel);

   modport bus (input tstate, mcycle, port_addr);

endinterface

/* design/program_counter.sv */
`timescale 1ns/10ps
// program counter with increment, jump target low byte latch and jump load
module program_counter
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic [i8080_pkg::DATA_W-1:0] data_latch,
   cycle_ctrl_if.counter                ctl,
   output logic [i8080_pkg::ADDR_W-1:0] pc
);

   logic [i8080_pkg::DATA_W-1:0] target_lo;

   // low byte of the jump target, from the first operand read
   always_ff @(posedge clk)
   begin
      if (ctl.lo_we)
         target_lo <= data_latch;
   end

   // high byte comes straight from the second operand read
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         pc <= '0;
      else if (ctl.pc_load)
         pc <= {data_latch, target_lo};
      else if (ctl.pc_inc)
         pc <= pc + 1'b1;
   end

endmodule

/* design/cycle_sequencer.sv */
`timescale 1ns/10ps
// instruction register, opcode decode and the machine-cycle / T-state sequencer
module cycle_sequencer
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         ready,
   input  logic [i8080_pkg::DATA_W-1:0] data_latch,
   input  logic [3:0]                   flags,
   cycle_ctrl_if.seq                    ctl
);

   i8080_pkg::opcode_u           ir;
   i8080_pkg::tstate_e           tstate;
   i8080_pkg::mcycle_e           mcycle;
   logic [1:0]                   rd_cnt;
   logic [i8080_pkg::DATA_W-1:0] port_q;

   logic       is_hlt;
   logic       is_mov;
   logic       is_mvi;
   logic       is_alu;
   logic       is_alui;
   logic       is_jmp;
   logic       is_jcc;
   logic       is_out;
   logic [1:0] n_reads;
   logic       cond_flag;
   logic       jump_taken;
   logic       exec_t4;
   logic       exec_rd;
   logic       last_rd;

   // opcode decode, memory operand forms fall out as no-ops
   always_comb
   begin
      is_hlt  = ir == i8080_pkg::OP_HLT;
      is_mov  = ir.mov.group == 2'b01 && ir.mov.dst != i8080_pkg::REG_M
                && ir.mov.src != i8080_pkg::REG_M;
      is_mvi  = (ir & i8080_pkg::OP_ROW_MASK) == i8080_pkg::OP_MVI_MASK
                && ir.mov.dst != i8080_pkg::REG_M;
      is_alu  = ir.op.group == 2'b10 && ir.op.src != i8080_pkg::REG_M;
      // immediate ALU forms sit in the memory slot of row 11
      is_alui = ir.op.group == 2'b11 && ir.op.src == i8080_pkg::REG_M;
      is_jmp  = ir == i8080_pkg::OP_JMP;
      is_jcc  = (ir & i8080_pkg::OP_ROW_MASK) == i8080_pkg::OP_JCC_MASK;
      is_out  = ir == i8080_pkg::OP_OUT;

      if (is_jmp || is_jcc)
         n_reads = 2'd2;
      else if (is_mvi || is_alui || is_out)
         n_reads = 2'd1;
      else
         n_reads = 2'd0;
   end

   // ccc field: upper two bits pick the flag, bit 0 the wanted value
   always_comb
   begin
      case (ir.mov.dst[2:1])
         2'b00:   cond_flag = flags[i8080_pkg::FLAG_Z];
         2'b01:   cond_flag = flags[i8080_pkg::FLAG_CY];
         2'b10:   cond_flag = flags[i8080_pkg::FLAG_P];
         default: cond_flag = flags[i8080_pkg::FLAG_S];
      endcase
      jump_taken = is_jmp || (is_jcc && cond_flag == ir.mov.dst[0]);
   end

   assign exec_t4 = mcycle == i8080_pkg::FETCH && tstate == i8080_pkg::T4;
   assign exec_rd = mcycle == i8080_pkg::READ && tstate == i8080_pkg::T3;
   assign last_rd = rd_cnt == 2'd1;

   assign ctl.tstate    = tstate;
   assign ctl.mcycle    = mcycle;
   assign ctl.reg_we    = ((exec_t4 && is_mov) || (exec_rd && is_mvi))
                          && ir.mov.dst != i8080_pkg::REG_A;
   assign ctl.acc_we    = ((exec_t4 && is_mov) || (exec_rd && is_mvi))
                          && ir.mov.dst == i8080_pkg::REG_A;
   assign ctl.alu_exec  = (exec_t4 && is_alu) || (exec_rd && is_alui);
   assign ctl.dst       = ir.mov.dst;
   assign ctl.src       = ir.mov.src;
   assign ctl.alu_op    = ir.op.alu_op;
   assign ctl.imm_sel   = mcycle == i8080_pkg::READ;
   // every opcode and operand byte advances the pc at the end of its T3
   assign ctl.pc_inc    = tstate == i8080_pkg::T3
                          && (mcycle == i8080_pkg::FETCH || mcycle == i8080_pkg::READ);
   assign ctl.lo_we     = exec_rd && (is_jmp || is_jcc) && !last_rd;
   assign ctl.pc_load   = exec_rd && last_rd && jump_taken;
   assign ctl.port_addr = port_q;

   always_ff @(posedge clk)
   begin
      if (exec_rd && is_out)
         port_q <= data_latch;
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         // parked at the end of a fetch holding a NOP, so T1 follows the first edge
         tstate <= i8080_pkg::T4;
         mcycle <= i8080_pkg::FETCH;
         ir     <= '0;
         rd_cnt <= '0;
      end
      else
      begin
         case (tstate)
            i8080_pkg::T1:
               tstate <= (mcycle == i8080_pkg::HALT) ? i8080_pkg::TW : i8080_pkg::T2;
            i8080_pkg::T2, i8080_pkg::TW:
            begin
               // halt never leaves TW
               if (ready && mcycle != i8080_pkg::HALT)
                  tstate <= i8080_pkg::T3;
               else
                  tstate <= i8080_pkg::TW;
            end
            i8080_pkg::T3:
            begin
               if (mcycle == i8080_pkg::FETCH)
               begin
                  ir     <= data_latch;
                  tstate <= i8080_pkg::T4;
               end
               else
               begin
                  tstate <= i8080_pkg::T1;
                  if (mcycle == i8080_pkg::READ)
                     rd_cnt <= rd_cnt - 1'b1;
                  if (mcycle == i8080_pkg::READ && !last_rd)
                     mcycle <= i8080_pkg::READ;
                  else if (mcycle == i8080_pkg::READ && is_out)
                     mcycle <= i8080_pkg::WRITE;
                  else
                     mcycle <= i8080_pkg::FETCH;
               end
            end
            i8080_pkg::T4:
            begin
               tstate <= i8080_pkg::T1;
               rd_cnt <= n_reads;
               if (is_hlt)
                  mcycle <= i8080_pkg::HALT;
               else if (n_reads != 2'd0)
                  mcycle <= i8080_pkg::READ;
               else
                  mcycle <= i8080_pkg::FETCH;
            end
            default:
            begin
               tstate <= i8080_pkg::T1;
               mcycle <= i8080_pkg::FETCH;
            end
         endcase
      end
   end

endmodule

/* design/register_file.sv */
`timescale 1ns/10ps
// general registers B, C, D, E, H and L, one read port and one write port
module register_file
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic [i8080_pkg::DATA_W-1:0] operand,
   output logic [i8080_pkg::DATA_W-1:0] rd_data,
   cycle_ctrl_if.datapath               ctl
);

   // codes 0 to 5, the accumulator lives in the ALU block
   logic [i8080_pkg::DATA_W-1:0] regs [0:5];

   always_comb
   begin
      if (ctl.src < i8080_pkg::REG_M)
         rd_data = regs[ctl.src];
      else
         rd_data = '0;
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < 6; i++)
            regs[i] <= '0;
      end
      else if (ctl.reg_we && ctl.dst < i8080_pkg::REG_M)
         regs[ctl.dst] <= operand;
   end

endmodule

/* design/alu_flags.sv */
`timescale 1ns/10ps
// accumulator, operand select, 8-bit adder and logic unit, Z/S/P/CY flags
module alu_flags
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic [i8080_pkg::DATA_W-1:0] rd_data,
   input  logic [i8080_pkg::DATA_W-1:0] data_latch,
   output logic [i8080_pkg::DATA_W-1:0] operand,
   output logic [i8080_pkg::DATA_W-1:0] acc,
   output logic [3:0]                   flags,
   cycle_ctrl_if.datapath               ctl
);

   logic [i8080_pkg::DATA_W-1:0] opnd_x;
   logic                         sub_op;
   logic                         logic_op;
   logic                         carry_in;
   logic [i8080_pkg::DATA_W:0]   sum;
   logic [i8080_pkg::DATA_W-1:0] result;
   logic                         cy_next;

   always_comb
   begin
      if (ctl.imm_sel)
         operand = data_latch;
      else if (ctl.src == i8080_pkg::REG_A)
         operand = acc;
      else
         operand = rd_data;
   end

   // subtraction runs through the adder with the operand inverted
   always_comb
   begin
      sub_op   = ctl.alu_op inside {i8080_pkg::SUB, i8080_pkg::SBB, i8080_pkg::CMP};
      logic_op = ctl.alu_op inside {i8080_pkg::ANA, i8080_pkg::XRA, i8080_pkg::ORA};
      opnd_x   = sub_op ? ~operand : operand;

      case (ctl.alu_op)
         i8080_pkg::ADC:                 carry_in = flags[i8080_pkg::FLAG_CY];
         i8080_pkg::SUB, i8080_pkg::CMP: carry_in = 1'b1;
         i8080_pkg::SBB:                 carry_in = ~flags[i8080_pkg::FLAG_CY];
         default:                        carry_in = 1'b0;
      endcase

      sum = {1'b0, acc} + {1'b0, opnd_x} + {8'd0, carry_in};

      case (ctl.alu_op)
         i8080_pkg::ANA: result = acc & operand;
         i8080_pkg::XRA: result = acc ^ operand;
         i8080_pkg::ORA: result = acc | operand;
         default:        result = sum[i8080_pkg::DATA_W-1:0];
      endcase

      // carry out of the inverted add is the complement of the borrow
      cy_next = logic_op ? 1'b0 : (sum[i8080_pkg::DATA_W] ^ sub_op);
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         acc   <= '0;
         flags <= '0;
      end
      else if (ctl.alu_exec)
      begin
         // compare only sets flags
         if (ctl.alu_op != i8080_pkg::CMP)
            acc <= result;
         flags[i8080_pkg::FLAG_Z]  <= ~|result;
         flags[i8080_pkg::FLAG_S]  <= result[i8080_pkg::DATA_W-1];
         flags[i8080_pkg::FLAG_P]  <= ~^result;
         flags[i8080_pkg::FLAG_CY] <= cy_next;
      end
      else if (ctl.acc_we)
         acc <= operand;
   end

endmodule

/* design/bus_interface.sv */
`timescale 1ns/10ps
// bus pins decoded from the cycle state, T1 status byte and read data capture
module bus_interface
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic [i8080_pkg::ADDR_W-1:0] pc,
   input  logic [i8080_pkg::DATA_W-1:0] acc,
   input  logic [i8080_pkg::DATA_W-1:0] data_in,
   input  logic                         ready,
   output logic [i8080_pkg::ADDR_W-1:0] addr,
   output logic [i8080_pkg::DATA_W-1:0] data_out,
   output logic                         data_oe,
   output logic                         sync,
   output logic                         dbin,
   output logic                         wr_n,
   output logic                         wait_state,
   output logic [i8080_pkg::DATA_W-1:0] data_latch,
   cycle_ctrl_if.bus                    ctl
);

   logic                         rd_cycle;
   logic                         wr_cycle;
   logic                         xfer_phase;
   logic [i8080_pkg::DATA_W-1:0] status;

   assign rd_cycle   = ctl.mcycle == i8080_pkg::FETCH || ctl.mcycle == i8080_pkg::READ;
   assign wr_cycle   = ctl.mcycle == i8080_pkg::WRITE;
   assign xfer_phase = ctl.tstate == i8080_pkg::T2 || ctl.tstate == i8080_pkg::TW;

   always_comb
   begin
      status                        = '0;
      status[i8080_pkg::STATUS_WO_N] = ~wr_cycle;
      status[i8080_pkg::STATUS_MEMR] = ~wr_cycle;
      status[i8080_pkg::STATUS_M1]   = ctl.mcycle == i8080_pkg::FETCH;
      status[i8080_pkg::STATUS_OUT]  = wr_cycle;
      status[i8080_pkg::STATUS_HLTA] = ctl.mcycle == i8080_pkg::HALT;
   end

   assign sync       = ctl.tstate == i8080_pkg::T1;
   assign dbin       = xfer_phase && rd_cycle;
   // write strobe spans T2, any waits and T3
   assign wr_n       = ~(wr_cycle && (xfer_phase || ctl.tstate == i8080_pkg::T3));
   assign wait_state = ctl.tstate == i8080_pkg::TW;
   assign data_oe    = sync || !wr_n;
   assign data_out   = sync ? status : acc;
   // output port number appears on both address bytes
   assign addr       = wr_cycle ? {2{ctl.port_addr}} : pc;

   // read data is taken on the edge that ends T2 or TW with ready high
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         data_latch <= '0;
      else if (dbin && ready)
         data_latch <= data_in;
   end

endmodule

/* design/i8080_lite.sv */
`timescale 1ns/10ps
// 8080-lite core top, sequencer and datapath blocks joined by the steering bundle
module i8080_lite
(
   input  logic                         clk,
   input  logic                         reset,
   output logic [i8080_pkg::ADDR_W-1:0] addr,
   input  logic [i8080_pkg::DATA_W-1:0] data_in,
   output logic [i8080_pkg::DATA_W-1:0] data_out,
   output logic                         data_oe,
   input  logic                         ready,
   output logic                         sync,
   output logic                         dbin,
   output logic                         wr_n,
   output logic                         wait_state
);

   logic [i8080_pkg::ADDR_W-1:0] pc;
   logic [i8080_pkg::DATA_W-1:0] data_latch;
   logic [i8080_pkg::DATA_W-1:0] acc;
   logic [i8080_pkg::DATA_W-1:0] operand;
   logic [i8080_pkg::DATA_W-1:0] rd_data;
   logic [3:0]                   flags;

   cycle_ctrl_if ctl ();

   cycle_sequencer i_cycle_sequencer
   (
      .clk        (clk),
      .reset      (reset),
      .ready      (ready),
      .data_latch (data_latch),
      .flags      (flags),
      .ctl        (ctl.seq)
   );

   program_counter i_program_counter
   (
      .clk        (clk),
      .reset      (reset),
      .data_latch (data_latch),
      .ctl        (ctl.counter),
      .pc         (pc)
   );

   register_file i_register_file
   (
      .clk        (clk),
      .reset      (reset),
      .operand    (operand),
      .rd_data    (rd_data),
      .ctl        (ctl.datapath)
   );

   alu_flags i_alu_flags
   (
      .clk        (clk),
      .reset      (reset),
      .rd_data    (rd_data),
      .data_latch (data_latch),
      .operand    (operand),
      .acc        (acc),
      .flags      (flags),
      .ctl        (ctl.datapath)
   );

   bus_interface i_bus_interface
   (
      .clk        (clk),
      .reset      (reset),
      .pc         (pc),
      .acc        (acc),
      .data_in    (data_in),
      .ready      (ready),
      .addr       (addr),
      .data_out   (data_out),
      .data_oe    (data_oe),
      .sync       (sync),
      .dbin       (dbin),
      .wr_n       (wr_n),
      .wait_state (wait_state),
      .data_latch (data_latch),
      .ctl        (ctl.bus)
   );

endmodule

/* verif/i8080_lite_properties.sv */
`timescale 1ns/10ps
// bus pin protocol checks bound to the 8080-lite core top
module i8080_lite_properties
(
   input logic                         clk,
   input logic                         reset,
   input logic                         sync,
   input logic                         dbin,
   input logic                         wr_n,
   input logic                         wait_state,
   input logic                         data_oe,
   input logic [i8080_pkg::DATA_W-1:0] data_out
);

   logic wr_cycle_q;

   // cycle type taken from the status byte shown in T1
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         wr_cycle_q <= 1'b0;
      else if (sync)
         wr_cycle_q <= ~data_out[i8080_pkg::STATUS_WO_N];
   end

   // read strobe and write strobe never together
   rd_wr_excl: assert property (@(posedge clk) disable iff (reset) !(dbin && !wr_n))
      else $error("dbin and wr_n active in the same cycle");

   sync_wait_excl: assert property (@(posedge clk) disable iff (reset) !(sync && wait_state))
      else $error("sync and wait_state active in the same cycle");

   // the core only drives the data bus for status or write data
   oe_when_allowed: assert property (@(posedge clk) disable iff (reset)
      data_oe |-> (sync || wr_cycle_q))
      else $error("data_oe high outside T1 and outside a write");

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/10ps
// testbench clock source, 40 ns period, power-on reset held for four cycles
module tb_clock_gen
(
   output logic clk,
   output logic reset
);

   initial
   begin
      clk   = 1'b0;
      reset = 1'b1;
      repeat (4) @(negedge clk);
      reset = 1'b0;
   end

   always #20 clk = ~clk;

endmodule

/* verif/tb_i8080_lite.sv */
`timescale 1ns/10ps
// testbench for the 8080-lite core with memory model, program table and write checker
module tb_i8080_lite;

   localparam int N_ALU = 16;

   // op, immediate form, carry in, a, b, expected accumulator
   localparam logic [28:0] ALU_TABLE [N_ALU] = '{
      {3'd0, 1'b0, 1'b0, 8'h12, 8'h34, 8'h46},
      {3'd0, 1'b1, 1'b0, 8'hf0, 8'h10, 8'h00},
      {3'd1, 1'b0, 1'b1, 8'h7f, 8'h00, 8'h80},
      {3'd1, 1'b1, 1'b0, 8'h01, 8'h02, 8'h03},
      {3'd2, 1'b0, 1'b0, 8'h05, 8'h07, 8'hfe},
      {3'd2, 1'b1, 1'b0, 8'h40, 8'h40, 8'h00},
      {3'd3, 1'b0, 1'b1, 8'h10, 8'h01, 8'h0e},
      {3'd3, 1'b1, 1'b1, 8'h00, 8'h00, 8'hff},
      {3'd4, 1'b0, 1'b0, 8'hf3, 8'h3c, 8'h30},
      {3'd4, 1'b1, 1'b0, 8'haa, 8'h55, 8'h00},
      {3'd5, 1'b0, 1'b0, 8'h5a, 8'hff, 8'ha5},
      {3'd5, 1'b1, 1'b0, 8'h81, 8'h01, 8'h80},
      {3'd6, 1'b0, 1'b0, 8'h01, 8'h02, 8'h03},
      {3'd6, 1'b1, 1'b0, 8'h00, 8'h00, 8'h00},
      {3'd7, 1'b0, 1'b0, 8'h20, 8'h30, 8'h20},
      {3'd7, 1'b1, 1'b0, 8'h30, 8'h30, 8'h30}
   };

   logic        clk;
   logic        por;
   logic        run_reset;
   logic        dut_reset;
   logic [15:0] addr;
   logic [7:0]  data_in;
   logic [7:0]  data_out;
   logic        data_oe;
   logic        ready;
   logic        sync;
   logic        dbin;
   logic        wr_n;
   logic        wait_state;

   logic [7:0]  mem [0:255];
   logic [23:0] writes [$];
   logic [23:0] expected [$];
   int          pc_w;
   int          pending;
   int          wait_total;
   int          wait_cycles;
   logic        quiet;
   logic        halted;
   logic        first_sync;
   logic        wr_seen;
   logic        waits_on;
   int unsigned limit;
   int unsigned cycles;
   int unsigned total_bytes;

   assign dut_reset = por | run_reset;

   tb_clock_gen i_clock_gen (.clk(clk), .reset(por));

   i8080_lite i_i8080_lite
   (
      .clk        (clk),
      .reset      (dut_reset),
      .addr       (addr),
      .data_in    (data_in),
      .data_out   (data_out),
      .data_oe    (data_oe),
      .ready      (ready),
      .sync       (sync),
      .dbin       (dbin),
      .wr_n       (wr_n),
      .wait_state (wait_state)
   );

   bind i8080_lite i8080_lite_properties i_props (.*);

   task automatic abort(input string why);
      if (why != "")
         $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("ERR %s got %h expected %h", name, got, exp);
         abort("");
      end
   endtask

   task automatic emit(input logic [7:0] b);
      mem[pc_w[7:0]] = b;
      pc_w++;
   endtask

   // 8080 arithmetic rules giving {z, s, p, cy, acc}
   function automatic logic [11:0] alu_model(input logic [2:0] op, input logic [7:0] a,
                                             input logic [7:0] b, input logic cy);
      logic [8:0] r9;
      logic [7:0] acc_new;
      case (op)
         3'd0:    r9 = {1'b0, a} + {1'b0, b};
         3'd1:    r9 = {1'b0, a} + {1'b0, b} + {8'd0, cy};
         3'd3:    r9 = {1'b0, a} - {1'b0, b} - {8'd0, cy};
         3'd4:    r9 = {1'b0, a & b};
         3'd5:    r9 = {1'b0, a ^ b};
         3'd6:    r9 = {1'b0, a | b};
         default: r9 = {1'b0, a} - {1'b0, b};
      endcase
      acc_new = (op == 3'd7) ? a : r9[7:0];
      return {r9[7:0] == 8'd0, r9[7], ~^r9[7:0], r9[8], acc_new};
   endfunction

   // jump conditions in ccc order NZ Z NC C PO PE P M
   function automatic logic cond_taken(input logic [2:0] k, input logic [3:0] zspc);
      logic z;
      logic s;
      logic p;
      logic cy;
      logic t;
      z  = zspc[3];
      s  = zspc[2];
      p  = zspc[1];
      cy = zspc[0];
      case (k)
         3'd0:    t = !z;
         3'd1:    t = z;
         3'd2:    t = !cy;
         3'd3:    t = cy;
         3'd4:    t = !p;
         3'd5:    t = p;
         3'd6:    t = !s;
         default: t = s;
      endcase
      return t;
   endfunction

   task automatic clear_mem();
      for (int i = 0; i < 256; i++)
         mem[i] = 8'(i) ^ 8'ha5;
      pc_w = 0;
      expected.delete();
   endtask

   task automatic build_moves();
      logic [7:0] v;
      clear_mem();
      for (int r = 0; r < 8; r++)
      begin
         if (r != 6)
         begin
            emit({2'b00, 3'(r), 3'b110});
            emit(8'h31 + 8'(r) * 8'h11);
         end
      end
      // A first before the moves overwrite it
      for (int r = 7; r >= 0; r--)
      begin
         if (r != 6)
         begin
            v = 8'h31 + 8'(r) * 8'h11;
            emit({2'b01, 3'd7, 3'(r)});
            emit(8'hd3);
            emit(8'h40 + 8'(r));
            expected.push_back({8'h40 + 8'(r), 8'h40 + 8'(r), v});
         end
      end
      // chain B -> C -> D -> E -> H -> L -> A
      emit(8'h06);
      emit(8'h5c);
      for (int r = 1; r < 6; r++)
         emit({2'b01, 3'(r), 3'(r - 1)});
      emit({2'b01, 3'd7, 3'd5});
      emit(8'hd3);
      emit(8'h4f);
      expected.push_back({8'h4f, 8'h4f, 8'h5c});
      emit(8'h76);
   endtask

   task automatic build_alu(input logic [28:0] row);
      logic [11:0] m;
      int          target;
      clear_mem();
      m = alu_model(row[28:26], row[23:16], row[15:8], row[24]);
      check("ref_model", {24'd0, m[7:0]}, {24'd0, row[7:0]});
      // preset carry with ff + 0 or ff + 1
      emit(8'h3e);
      emit(8'hff);
      emit(8'hc6);
      emit({7'd0, row[24]});
      emit(8'h3e);
      emit(row[23:16]);
      emit(8'h06);
      emit(row[15:8]);
      if (row[25])
      begin
         emit({2'b11, row[28:26], 3'b110});
         emit(row[15:8]);
      end
      else
         emit({2'b10, row[28:26], 3'b000});
      emit(8'hd3);
      emit(8'h10);
      expected.push_back({8'h10, 8'h10, m[7:0]});
      for (int k = 0; k < 8; k++)
      begin
         target = pc_w + 10;
         emit({2'b11, 3'(k), 3'b010});
         emit(8'(target));
         emit(8'h00);
         emit(8'h3e);
         emit(8'h20 + 8'(k));
         emit(8'hd3);
         emit(8'h20);
         emit(8'hc3);
         emit(8'(target + 4));
         emit(8'h00);
         emit(8'h3e);
         emit(8'h30 + 8'(k));
         emit(8'hd3);
         emit(8'h20);
         if (cond_taken(3'(k), m[11:8]))
            expected.push_back({8'h20, 8'h20, 8'h30 + 8'(k)});
         else
            expected.push_back({8'h20, 8'h20, 8'h20 + 8'(k)});
      end
      emit(8'h76);
   endtask

   task automatic run_program(input logic with_waits);
      @(posedge clk);
      quiet       = 1'b1;
      waits_on    = with_waits;
      writes.delete();
      first_sync  = 1'b1;
      halted      = 1'b0;
      pending     = 0;
      wait_total  = 0;
      wait_cycles = 0;
      @(negedge clk);
      run_reset = 1'b1;
      repeat (4) @(negedge clk);
      run_reset = 1'b0;
      @(posedge clk);
      quiet = 1'b0;
      while (!halted)
         @(posedge clk);
      repeat (8) @(posedge clk);
      check("wait_cycles", 32'(wait_cycles), 32'(wait_total));
      check("write_count", 32'(writes.size()), 32'(expected.size()));
      for (int i = 0; i < expected.size(); i++)
         check("write addr/data", {8'd0, writes[i]}, {8'd0, expected[i]});
   endtask

   // bus responder and monitor working on the falling edge
   always @(negedge clk)
   begin
      if (quiet)
         ready = 1'b1;
      else if (sync)
      begin
         wr_seen = 1'b0;
         check("data_oe", {31'd0, data_oe}, 32'd1);
         if (first_sync)
         begin
            check("first addr", {16'd0, addr}, 32'd0);
            check("status_m1", {31'd0, data_out[i8080_pkg::STATUS_M1]}, 32'd1);
            check("status_memr", {31'd0, data_out[i8080_pkg::STATUS_MEMR]}, 32'd1);
            first_sync = 1'b0;
         end
         if (halted)
            abort("sync seen after the halt cycle had started");
         if (data_out[i8080_pkg::STATUS_HLTA])
         begin
            halted  = 1'b1;
            pending = 0;
            ready   = 1'b1;
         end
         else
         begin
            pending    = waits_on ? int'($urandom % 4) : 0;
            wait_total += pending;
            ready      = pending == 0;
         end
      end
      else if (halted)
         check("wait_state", {31'd0, wait_state}, 32'd1);
      else
      begin
         if (wait_state)
         begin
            // a wait cycle must come from ready held low
            check("wait_state held", 32'(pending != 0), 32'd1);
            wait_cycles++;
            pending--;
            ready = pending == 0;
         end
         if (dbin)
         begin
            check("data_oe", {31'd0, data_oe}, 32'd0);
            data_in = mem[addr[7:0]];
         end
         if (!wr_n)
         begin
            check("data_oe", {31'd0, data_oe}, 32'd1);
            if (!wr_seen)
            begin
               writes.push_back({addr, data_out});
               wr_seen = 1'b1;
            end
         end
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles > limit)
         abort("timeout, the core stopped making progress");
   end

   initial
   begin
      void'($urandom(44));
      quiet     = 1'b1;
      halted    = 1'b0;
      ready     = 1'b1;
      data_in   = 8'h00;
      run_reset = 1'b0;
      waits_on  = 1'b0;
      cycles    = 0;
      limit     = 32'hffff_ffff;
      // size of all programs with each one run twice
      build_moves();
      total_bytes = 32'(pc_w);
      for (int e = 0; e < N_ALU; e++)
      begin
         build_alu(ALU_TABLE[e]);
         total_bytes += 32'(pc_w);
      end
      limit = total_bytes * 2 * 4 * 5 + 200;
      for (int e = 0; e <= N_ALU; e++)
      begin
         for (int mode = 0; mode < 2; mode++)
         begin
            if (e == 0)
               build_moves();
            else
               build_alu(ALU_TABLE[e - 1]);
            run_program(mode == 1);
         end
      end
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

/* i8080_lite.f */
design/i8080_pkg.sv
design/cycle_ctrl_if.sv
design/program_counter.sv
design/cycle_sequencer.sv
design/register_file.sv
design/alu_flags.sv
design/bus_interface.sv
design/i8080_lite.sv
verif/i8080_lite_properties.sv
verif/tb_clock_gen.sv
verif/tb_i8080_lite.sv

/* Makefile */
SRCS := $(wildcard design/*.sv verif/*.sv)

.PHONY: all run clean

all: obj_dir/Vtb_i8080_lite

obj_dir/Vtb_i8080_lite: $(SRCS) i8080_lite.f
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_i8080_lite -f i8080_lite.f \
		-o Vtb_i8080_lite

run: obj_dir/Vtb_i8080_lite
	./obj_dir/Vtb_i8080_lite

clean:
	rm -rf obj_dir
